// File: rv_fetch_pkg.sv
// fetch side widths, reset pc, queue sizing and fetch state encoding

package rv_fetch_pkg;

	// datapath widths
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned XLEN_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [XLEN_W-1:0] inst_t;

	// first fetch address after reset
	localparam addr_t RESET_PC = 32'h0000_0000;

	// fetch queue sizing, depth is a power of two
	localparam int unsigned QUEUE_DEPTH = 4;
	localparam int unsigned QPTR_W = 2;

	typedef logic [QPTR_W-1:0] qptr_t;
	// one extra bit so a full queue is distinct from an empty one
	typedef logic [QPTR_W:0] qcnt_t;

	// APB requester states
	typedef enum logic [1:0] {
		FETCH_IDLE   = 2'b00,
		FETCH_SETUP  = 2'b01,
		FETCH_ACCESS = 2'b10
	} fetch_state_t;

endpackage

// File: rv_isa_pkg.sv
// RV32 opcode, funct3 and funct7 fields and the special system words
// used by the instruction legality check

package rv_isa_pkg;

	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [6:0] funct7_t;

	// major opcodes, bits 6:0
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;
	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_JALR   = 7'b1100111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_SYSTEM = 7'b1110011;

	// jalr only defines funct3 zero
	localparam funct3_t F3_JALR = 3'b000;

	// loads and stores
	localparam funct3_t F3_LB  = 3'b000;
	localparam funct3_t F3_LH  = 3'b001;
	localparam funct3_t F3_LW  = 3'b010;
	localparam funct3_t F3_LBU = 3'b100;
	localparam funct3_t F3_LHU = 3'b101;
	localparam funct3_t F3_SB  = 3'b000;
	localparam funct3_t F3_SH  = 3'b001;
	localparam funct3_t F3_SW  = 3'b010;

	// op-imm group
	localparam funct3_t F3_ADDI      = 3'b000;
	localparam funct3_t F3_SLLI      = 3'b001;
	localparam funct3_t F3_SLTI      = 3'b010;
	localparam funct3_t F3_SLTIU     = 3'b011;
	localparam funct3_t F3_XORI      = 3'b100;
	localparam funct3_t F3_SRLI_SRAI = 3'b101;
	localparam funct3_t F3_ORI       = 3'b110;
	localparam funct3_t F3_ANDI      = 3'b111;

	// csr access
	localparam funct3_t F3_CSRRW = 3'b001;
	localparam funct3_t F3_CSRRS = 3'b010;

	// shift immediates, bits 31:25
	localparam funct7_t F7_ZERO = 7'b0000000;
	localparam funct7_t F7_SRA  = 7'b0100000;

	// system words matched on all 32 bits
	localparam logic [31:0] INST_ECALL  = 32'h0000_0073;
	localparam logic [31:0] INST_EBREAK = 32'h0010_0073;
	localparam logic [31:0] INST_MRET   = 32'h3020_0073;

endpackage

// File: fetch_unit.sv
`timescale 1ns/1ps
// fetch unit: pc register, redirect priority and APB read requester
// that pushes each fetched pc and instruction pair

module fetch_unit (
	input  logic                clk,
	input  logic                rst,
	input  logic                csr_jmp_i,
	input  rv_fetch_pkg::addr_t csr_pc_i,
	input  logic                jmp_flag_i,
	input  rv_fetch_pkg::addr_t jmp_target_i,
	input  logic                branch_request_i,
	input  logic                branch_flag_i,
	input  rv_fetch_pkg::addr_t branch_target_i,
	input  logic                full_i,
	output logic                psel_o,
	output logic                penable_o,
	output rv_fetch_pkg::addr_t paddr_o,
	output logic                pwrite_o,
	input  rv_fetch_pkg::inst_t prdata_i,
	input  logic                pready_i,
	input  logic                pslverr_i,
	output logic                push_o,
	output rv_fetch_pkg::addr_t push_pc_o,
	output rv_fetch_pkg::inst_t push_inst_o,
	output logic                flush_o
);

	rv_fetch_pkg::fetch_state_t state;
	rv_fetch_pkg::fetch_state_t state_next;
	rv_fetch_pkg::addr_t        pc;
	rv_fetch_pkg::addr_t        pc_next;
	rv_fetch_pkg::addr_t        pc_plus4;
	rv_fetch_pkg::addr_t        redirect_pc;
	rv_fetch_pkg::addr_t        req_addr;
	logic                       redirect;
	logic                       xfer_done;
	logic                       stale;

	assign redirect = csr_jmp_i | jmp_flag_i | (branch_request_i & branch_flag_i);

	// trap or mret target wins, then jump, then taken branch
	always_comb begin
		if (csr_jmp_i) begin
			redirect_pc = csr_pc_i;
		end else if (jmp_flag_i) begin
			redirect_pc = jmp_target_i;
		end else begin
			redirect_pc = branch_target_i;
		end
	end

	assign pc_plus4  = pc + rv_fetch_pkg::addr_t'(4);
	assign xfer_done = (state == rv_fetch_pkg::FETCH_ACCESS) & pready_i;

	// a stale transfer leaves the pc on the redirect target
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (xfer_done && !stale) begin
			pc_next = pc_plus4;
		end else begin
			pc_next = pc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= rv_fetch_pkg::RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	// one transfer at a time, full only looked at before setup
	always_comb begin
		state_next = state;
		case (state)
			rv_fetch_pkg::FETCH_IDLE: begin
				if (!full_i) begin
					state_next = rv_fetch_pkg::FETCH_SETUP;
				end
			end
			rv_fetch_pkg::FETCH_SETUP: begin
				state_next = rv_fetch_pkg::FETCH_ACCESS;
			end
			rv_fetch_pkg::FETCH_ACCESS: begin
				if (pready_i) begin
					state_next = rv_fetch_pkg::FETCH_IDLE;
				end
			end
			default: begin
				state_next = rv_fetch_pkg::FETCH_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= rv_fetch_pkg::FETCH_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// address held for the whole transfer, even across a redirect
	always_ff @(posedge clk) begin
		if (state == rv_fetch_pkg::FETCH_IDLE && state_next == rv_fetch_pkg::FETCH_SETUP) begin
			req_addr <= pc_next;
		end
	end

	// redirect while a read is outstanding, its data is dropped
	always_ff @(posedge clk) begin
		if (rst) begin
			stale <= 1'b0;
		end else if (state == rv_fetch_pkg::FETCH_IDLE || xfer_done) begin
			stale <= 1'b0;
		end else if (redirect) begin
			stale <= 1'b1;
		end
	end

	assign psel_o    = (state != rv_fetch_pkg::FETCH_IDLE);
	assign penable_o = (state == rv_fetch_pkg::FETCH_ACCESS);
	assign paddr_o   = req_addr;
	assign pwrite_o  = 1'b0;

	// an error reply is queued like any other word, pslverr_i is not acted on
	assign push_o      = xfer_done & ~stale & ~redirect;
	assign push_pc_o   = req_addr;
	assign push_inst_o = prdata_i;
	assign flush_o     = redirect;

endmodule

// File: fetch_queue.sv
`timescale 1ns/1ps
// flushable FIFO of pc and instruction pairs between fetch and check

module fetch_queue (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush_i,
	input  logic                push_i,
	input  rv_fetch_pkg::addr_t push_pc_i,
	input  rv_fetch_pkg::inst_t push_inst_i,
	output logic                full_o,
	input  logic                pop_i,
	output logic                head_valid_o,
	output rv_fetch_pkg::addr_t head_pc_o,
	output rv_fetch_pkg::inst_t head_inst_o
);

	rv_fetch_pkg::addr_t pc_mem   [rv_fetch_pkg::QUEUE_DEPTH];
	rv_fetch_pkg::inst_t inst_mem [rv_fetch_pkg::QUEUE_DEPTH];
	rv_fetch_pkg::qptr_t wr_ptr;
	rv_fetch_pkg::qptr_t rd_ptr;
	rv_fetch_pkg::qcnt_t count;
	logic                do_push;
	logic                do_pop;

	assign full_o       = (count == rv_fetch_pkg::qcnt_t'(rv_fetch_pkg::QUEUE_DEPTH));
	assign head_valid_o = (count != '0);
	assign head_pc_o    = pc_mem[rd_ptr];
	assign head_inst_o  = inst_mem[rd_ptr];

	assign do_push = push_i & ~full_o;
	assign do_pop  = pop_i & head_valid_o;

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			pc_mem[wr_ptr]   <= push_pc_i;
			inst_mem[wr_ptr] <= push_inst_i;
		end
	end

	// pointers wrap on their own since depth is a power of two
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// flush wins over a push in the same cycle
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: inst_checker.sv
`timescale 1ns/1ps
// output stage: legality check on the queue head, held until issue

module inst_checker (
	input  logic                clk,
	input  logic                rst,
	input  logic                flush_i,
	input  logic                head_valid_i,
	input  rv_fetch_pkg::addr_t head_pc_i,
	input  rv_fetch_pkg::inst_t head_inst_i,
	output logic                pop_o,
	output logic                issue_valid_o,
	output rv_fetch_pkg::addr_t issue_pc_o,
	output rv_fetch_pkg::inst_t issue_inst_o,
	output logic                issue_illegal_o,
	input  logic                issue_ready_i
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::funct7_t funct7;
	logic                legal;
	logic                load;

	assign opcode = head_inst_i[6:0];
	assign funct3 = head_inst_i[14:12];
	assign funct7 = head_inst_i[31:25];

	// accepted subset of RV32I plus csr and the three system words
	always_comb begin
		legal = 1'b0;
		case (opcode)
			rv_isa_pkg::OPC_LUI,
			rv_isa_pkg::OPC_AUIPC,
			rv_isa_pkg::OPC_JAL,
			rv_isa_pkg::OPC_BRANCH,
			rv_isa_pkg::OPC_OP: legal = 1'b1;
			rv_isa_pkg::OPC_JALR: legal = (funct3 == rv_isa_pkg::F3_JALR);
			rv_isa_pkg::OPC_LOAD: begin
				legal = funct3 inside {rv_isa_pkg::F3_LB, rv_isa_pkg::F3_LH,
					rv_isa_pkg::F3_LW, rv_isa_pkg::F3_LBU, rv_isa_pkg::F3_LHU};
			end
			rv_isa_pkg::OPC_STORE: begin
				legal = funct3 inside {rv_isa_pkg::F3_SB, rv_isa_pkg::F3_SH,
					rv_isa_pkg::F3_SW};
			end
			rv_isa_pkg::OPC_OP_IMM: begin
				// shifts also need a valid funct7
				if (funct3 == rv_isa_pkg::F3_SLLI) begin
					legal = (funct7 == rv_isa_pkg::F7_ZERO);
				end else if (funct3 == rv_isa_pkg::F3_SRLI_SRAI) begin
					legal = (funct7 == rv_isa_pkg::F7_ZERO) || (funct7 == rv_isa_pkg::F7_SRA);
				end else begin
					legal = 1'b1;
				end
			end
			rv_isa_pkg::OPC_SYSTEM: begin
				legal = (funct3 == rv_isa_pkg::F3_CSRRW) || (funct3 == rv_isa_pkg::F3_CSRRS) ||
					(head_inst_i == rv_isa_pkg::INST_ECALL) ||
					(head_inst_i == rv_isa_pkg::INST_EBREAK) ||
					(head_inst_i == rv_isa_pkg::INST_MRET);
			end
			default: legal = 1'b0;
		endcase
	end

	// take the head when empty or when the current item leaves
	assign load  = head_valid_i & (~issue_valid_o | issue_ready_i) & ~flush_i;
	assign pop_o = load;

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			issue_valid_o <= 1'b0;
		end else if (load) begin
			issue_valid_o <= 1'b1;
		end else if (issue_ready_i) begin
			issue_valid_o <= 1'b0;
		end
	end

	// payload only changes on a load, so it holds under back-pressure
	always_ff @(posedge clk) begin
		if (load) begin
			issue_pc_o      <= head_pc_i;
			issue_inst_o    <= head_inst_i;
			issue_illegal_o <= ~legal;
		end
	end

endmodule

// File: rv_fetch_top.sv
`timescale 1ns/1ps
// instruction fetch top: fetch unit, fetch queue and instruction checker

module rv_fetch_top (
	input  logic                clk,
	input  logic                rst,
	// redirects from execute
	input  logic                csr_jmp_i,
	input  rv_fetch_pkg::addr_t csr_pc_i,
	input  logic                jmp_flag_i,
	input  rv_fetch_pkg::addr_t jmp_target_i,
	input  logic                branch_request_i,
	input  logic                branch_flag_i,
	input  rv_fetch_pkg::addr_t branch_target_i,
	// APB requester to instruction memory
	output logic                psel_o,
	output logic                penable_o,
	output rv_fetch_pkg::addr_t paddr_o,
	output logic                pwrite_o,
	input  rv_fetch_pkg::inst_t prdata_i,
	input  logic                pready_i,
	input  logic                pslverr_i,
	// issue side
	output logic                issue_valid_o,
	output rv_fetch_pkg::addr_t issue_pc_o,
	output rv_fetch_pkg::inst_t issue_inst_o,
	output logic                issue_illegal_o,
	input  logic                issue_ready_i
);

	logic                push;
	rv_fetch_pkg::addr_t push_pc;
	rv_fetch_pkg::inst_t push_inst;
	logic                flush;
	logic                full;
	logic                pop;
	logic                head_valid;
	rv_fetch_pkg::addr_t head_pc;
	rv_fetch_pkg::inst_t head_inst;

	fetch_unit i_fetch_unit (
		.clk              (clk),
		.rst              (rst),
		.csr_jmp_i        (csr_jmp_i),
		.csr_pc_i         (csr_pc_i),
		.jmp_flag_i       (jmp_flag_i),
		.jmp_target_i     (jmp_target_i),
		.branch_request_i (branch_request_i),
		.branch_flag_i    (branch_flag_i),
		.branch_target_i  (branch_target_i),
		.full_i           (full),
		.psel_o           (psel_o),
		.penable_o        (penable_o),
		.paddr_o          (paddr_o),
		.pwrite_o         (pwrite_o),
		.prdata_i         (prdata_i),
		.pready_i         (pready_i),
		.pslverr_i        (pslverr_i),
		.push_o           (push),
		.push_pc_o        (push_pc),
		.push_inst_o      (push_inst),
		.flush_o          (flush)
	);

	fetch_queue i_fetch_queue (
		.clk          (clk),
		.rst          (rst),
		.flush_i      (flush),
		.push_i       (push),
		.push_pc_i    (push_pc),
		.push_inst_i  (push_inst),
		.full_o       (full),
		.pop_i        (pop),
		.head_valid_o (head_valid),
		.head_pc_o    (head_pc),
		.head_inst_o  (head_inst)
	);

	inst_checker i_inst_checker (
		.clk             (clk),
		.rst             (rst),
		.flush_i         (flush),
		.head_valid_i    (head_valid),
		.head_pc_i       (head_pc),
		.head_inst_i     (head_inst),
		.pop_o           (pop),
		.issue_valid_o   (issue_valid_o),
		.issue_pc_o      (issue_pc_o),
		.issue_inst_o    (issue_inst_o),
		.issue_illegal_o (issue_illegal_o),
		.issue_ready_i   (issue_ready_i)
	);

endmodule

// File: tb_rv_fetch.sv
`timescale 1ns/1ps
// testbench for the fetch subsystem: APB memory model, random redirects,
// issue back-pressure and a pc and legality reference model

module tb_rv_fetch;

	localparam int NUM_ITEMS    = 2000;
	localparam int ITEM_TIMEOUT = 200;

	logic        clk = 1'b0;
	logic        rst;
	logic        csr_jmp_i;
	logic [31:0] csr_pc_i;
	logic        jmp_flag_i;
	logic [31:0] jmp_target_i;
	logic        branch_request_i;
	logic        branch_flag_i;
	logic [31:0] branch_target_i;
	logic        psel_o;
	logic        penable_o;
	logic [31:0] paddr_o;
	logic        pwrite_o;
	logic [31:0] prdata_i;
	logic        pready_i;
	logic        pslverr_i;
	logic        issue_valid_o;
	logic [31:0] issue_pc_o;
	logic [31:0] issue_inst_o;
	logic        issue_illegal_o;
	logic        issue_ready_i;

	logic [31:0] mem [256];

	// reference model state
	logic [31:0] exp_pc;
	logic [31:0] redirect_pc;
	logic        redirect;
	logic        started;
	logic        hold_pending;
	logic [31:0] held_pc;
	logic [31:0] held_inst;
	logic        held_illegal;
	int          handshakes;
	int          idle_cycles;

	// APB memory model, phase 0 idle, 1 setup, 2 access waiting, 3 access done
	int          apb_phase;
	int          wait_left;
	logic        apb_err;
	logic [31:0] apb_addr;

	rv_fetch_top i_rv_fetch_top (.*);

	always #10 clk = ~clk;

	task automatic report_failure(input string why);
		$display(">>> FAIL");
		$display("%s", why);
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		report_failure($sformatf("mismatch %s expected %08h actual %08h", name, expected, actual));
	endtask

	// accepted RV32 subset, encodings kept local to the testbench
	function automatic logic is_legal_word(input logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			// lui, auipc, jal, branch and R-type
			7'b0110111, 7'b0010111, 7'b1101111, 7'b1100011, 7'b0110011: return 1'b1;
			7'b1100111: return f3 == 3'd0;
			// loads lb lh lw lbu lhu
			7'b0000011: return f3 != 3'd3 && f3 < 3'd6;
			7'b0100011: return f3 < 3'd3;
			// op-imm, shifts need funct7
			7'b0010011: return (f3 == 3'd1) ? (f7 == 7'h00) :
				(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			// csrrw, csrrs and the exact system words
			7'b1110011: return f3 == 3'd1 || f3 == 3'd2 || w == 32'h0000_0073 ||
				w == 32'h0010_0073 || w == 32'h3020_0073;
			default: return 1'b0;
		endcase
	endfunction

	function automatic logic [31:0] random_legal_word();
		logic [31:0] w;
		logic [2:0]  idx;
		w   = $urandom;
		idx = $urandom % 5;
		case ($urandom % 11)
			0: w[6:0] = 7'b0110111;
			1: w[6:0] = 7'b0010111;
			2: w[6:0] = 7'b1101111;
			3: w[14:0] = {3'd0, w[11:7], 7'b1100111};
			4: w[6:0] = 7'b1100011;
			5: w[6:0] = 7'b0110011;
			6: w[14:0] = {(idx < 3'd3) ? idx : idx + 3'd1, w[11:7], 7'b0000011};
			7: w[14:0] = {(idx < 3'd3) ? idx : idx - 3'd3, w[11:7], 7'b0100011};
			8: begin
				w[6:0] = 7'b0010011;
				if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
					w[31:25] = (w[14:12] == 3'd5 && w[30]) ? 7'h20 : 7'h00;
				end
			end
			9: w[14:0] = {2'b00, idx[0], w[11:7], 7'b1110011} + 15'h1000;
			default: w = (idx == 3'd0) ? 32'h0000_0073 :
				(idx == 3'd1) ? 32'h0010_0073 : 32'h3020_0073;
		endcase
		return w;
	endfunction

	task automatic step_apb();
		assert (pwrite_o == 1'b0) else report_mismatch("pwrite_o", 32'h0, 32'(pwrite_o));
		pready_i  = 1'b0;
		pslverr_i = 1'b0;
		prdata_i  = $urandom;
		if (psel_o && !penable_o) begin
			assert (apb_phase != 1 && apb_phase != 2)
			else report_failure("setup phase while a transfer was still open");
			apb_addr  = paddr_o;
			wait_left = $urandom % 4;
			apb_err   = ($urandom % 32) == 0;
			apb_phase = 1;
		end else if (psel_o) begin
			assert (apb_phase == 1 || apb_phase == 2)
			else report_failure("access phase without a preceding setup phase");
			assert (paddr_o == apb_addr) else report_mismatch("paddr_o", apb_addr, paddr_o);
			if (wait_left == 0) begin
				pready_i  = 1'b1;
				pslverr_i = apb_err;
				prdata_i  = mem[paddr_o[9:2]];
				apb_phase = 3;
			end else begin
				wait_left--;
				apb_phase = 2;
			end
		end else begin
			assert (!penable_o) else report_failure("penable_o high without psel_o");
			assert (apb_phase != 1 && apb_phase != 2)
			else report_failure("transfer left before pready");
			apb_phase = 0;
		end
	endtask

	task automatic drive_redirect();
		logic [2:0] src;
		csr_pc_i        = ($urandom % 256) << 2;
		jmp_target_i    = ($urandom % 256) << 2;
		branch_target_i = ($urandom % 256) << 2;
		src             = $urandom % 7 + 1;
		if (started && ($urandom % 100) < 5) begin
			csr_jmp_i        = src[2];
			jmp_flag_i       = src[1];
			branch_request_i = src[0];
			branch_flag_i    = src[0];
		end else begin
			// a branch request without a taken flag, or the reverse
			csr_jmp_i        = 1'b0;
			jmp_flag_i       = 1'b0;
			branch_request_i = $urandom % 2;
			branch_flag_i    = !branch_request_i && ($urandom % 2);
		end
		redirect = csr_jmp_i || jmp_flag_i || (branch_request_i && branch_flag_i);
		if (csr_jmp_i) begin
			redirect_pc = csr_pc_i;
		end else if (jmp_flag_i) begin
			redirect_pc = jmp_target_i;
		end else begin
			redirect_pc = branch_target_i;
		end
	endtask

	task automatic step_issue();
		if (hold_pending) begin
			assert (issue_valid_o) else report_failure("issue_valid_o dropped while stalled");
			assert (issue_pc_o == held_pc) else report_mismatch("issue_pc_o", held_pc, issue_pc_o);
			assert (issue_inst_o == held_inst)
			else report_mismatch("issue_inst_o", held_inst, issue_inst_o);
			assert (issue_illegal_o == held_illegal)
			else report_mismatch("issue_illegal_o", 32'(held_illegal), 32'(issue_illegal_o));
		end
		issue_ready_i = ($urandom % 10) >= 3;
		if (issue_valid_o && issue_ready_i) begin
			assert (issue_pc_o == exp_pc) else report_mismatch("issue_pc_o", exp_pc, issue_pc_o);
			assert (issue_inst_o == mem[exp_pc[9:2]])
			else report_mismatch("issue_inst_o", mem[exp_pc[9:2]], issue_inst_o);
			assert (issue_illegal_o == !is_legal_word(issue_inst_o))
			else report_mismatch("issue_illegal_o", 32'(!is_legal_word(issue_inst_o)),
				32'(issue_illegal_o));
			handshakes++;
			exp_pc      = exp_pc + 32'd4;
			idle_cycles = 0;
			started     = 1'b1;
		end else begin
			idle_cycles++;
		end
		// a flush may clear a stalled item, so no hold is expected then
		hold_pending = issue_valid_o && !issue_ready_i && !redirect;
		held_pc      = issue_pc_o;
		held_inst    = issue_inst_o;
		held_illegal = issue_illegal_o;
		if (redirect) begin
			exp_pc = redirect_pc;
		end
	endtask

	initial begin
		void'($urandom(26));
		rst              = 1'b1;
		csr_jmp_i        = 1'b0;
		csr_pc_i         = '0;
		jmp_flag_i       = 1'b0;
		jmp_target_i     = '0;
		branch_request_i = 1'b0;
		branch_flag_i    = 1'b0;
		branch_target_i  = '0;
		prdata_i         = '0;
		pready_i         = 1'b0;
		pslverr_i        = 1'b0;
		issue_ready_i    = 1'b0;
		exp_pc           = 32'h0000_0000;
		started          = 1'b0;
		hold_pending     = 1'b0;
		handshakes       = 0;
		idle_cycles      = 0;
		apb_phase        = 0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = (($urandom % 10) < 7) ? random_legal_word() : $urandom;
		end
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		assert (!psel_o) else report_mismatch("psel_o", 32'h0, 32'(psel_o));
		assert (!penable_o) else report_mismatch("penable_o", 32'h0, 32'(penable_o));
		assert (!issue_valid_o) else report_mismatch("issue_valid_o", 32'h0, 32'(issue_valid_o));
		while (handshakes < NUM_ITEMS && idle_cycles < ITEM_TIMEOUT) begin
			step_apb();
			drive_redirect();
			step_issue();
			@(posedge clk);
			#1;
		end
		if (handshakes == NUM_ITEMS) begin
			$display(">>> PASS");
			$finish;
		end else begin
			$display(">>> FAIL");
			$display("timeout, no instruction issued for %0d cycles", ITEM_TIMEOUT);
			$fatal(1, "timeout");
		end
	end

endmodule

// File: rv_fetch.f
rv_fetch_pkg.sv
rv_isa_pkg.sv
fetch_unit.sv
fetch_queue.sv
inst_checker.sv
rv_fetch_top.sv
tb_rv_fetch.sv
